//--- bench/cache_input_vectors.txt
# columns: op port addr wdata expected, the last three in hex
# op R read, W write, P paired read (I line then D line), F flush, C clear, M memory word check
# read miss then hit on both ports
R D 00000040 00000000 c0de0010
R D 00000040 00000000 c0de0010
R I 00000080 00000000 c0de0020
R I 00000080 00000000 c0de0020
# write-back on eviction, then refetch of the written word
W D 00000104 12345678 00000000
R D 00000144 00000000 c0de0051
M D 00000104 00000000 12345678
R D 00000104 00000000 12345678
W D 00000108 aabbccdd 00000000
R D 00000108 00000000 aabbccdd
# both ports miss together
P I 00000200 00000000 c0de0080
P D 00000304 00000000 c0de00c1
W D 00000348 55aa55aa 00000000
P I 00000244 00000000 c0de0091
P D 00000388 00000000 c0de00e2
M D 00000348 00000000 55aa55aa
M D 00000108 00000000 aabbccdd
# dirty lines reach memory through flush
W D 00000010 11111111 00000000
W D 00000014 22222222 00000000
W D 0000003c 33333333 00000000
F D 00000000 00000000 00000000
M D 00000010 00000000 11111111
M D 00000014 00000000 22222222
M D 0000003c 00000000 33333333
R D 00000010 00000000 11111111
# clear drops dirty data
W D 00000020 deadbeef 00000000
C D 00000000 00000000 00000000
R D 00000020 00000000 c0de0008
M D 00000020 00000000 c0de0008
R I 00000080 00000000 c0de0020

//--- src.f
src/cache_pkg.sv
src/l1_cache.sv
src/memory_arbiter.sv
src/cache_subsystem.sv
bench/mem_model.sv
bench/tb_cache_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cache subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_cache_subsystem \
  -f src.f --Mdir "$BUILD_DIR" -o sim_cache
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

"./$BUILD_DIR/sim_cache" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0

//--- bench/tb_cache_subsystem.sv
/*
 * testbench for the two-cache memory front end
 * reads operation vectors, drives both CPU ports, checks read data and memory
 * timeout scaled by the number of vectors
 */

`timescale 1ns/1ps

module tb_cache_subsystem import cache_pkg::*; ();

  localparam int INDEX_W        = 4;
  localparam int CYCLES_PER_VEC = 64;

  logic  clk = 1'b0;
  logic  rst;
  logic  flush;
  logic  clear;
  logic  flush_done;
  logic  clear_done;
  logic  icpu_ren;
  addr_t icpu_addr;
  word_t icpu_rdata;
  logic  icpu_busy;
  logic  dcpu_ren;
  logic  dcpu_wen;
  addr_t dcpu_addr;
  word_t dcpu_wdata;
  word_t dcpu_rdata;
  logic  dcpu_busy;
  logic  mem_ren;
  logic  mem_wen;
  addr_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;
  logic  mem_busy;

  // vector columns
  logic [7:0] vec_op [$];
  logic [7:0] vec_port [$];
  addr_t      vec_addr [$];
  word_t      vec_wdata [$];
  word_t      vec_exp [$];

  int cycle_cnt = 0;
  int cycle_limit = 0;

  // 8 ns period
  always #4 clk = ~clk;

  cache_subsystem #(.INDEX_W(INDEX_W)) u_dut (
    .CLK(clk), .i_rst(rst), .i_flush(flush), .i_clear(clear),
    .o_flush_done(flush_done), .o_clear_done(clear_done),
    .i_icpu_ren(icpu_ren), .i_icpu_addr(icpu_addr),
    .o_icpu_rdata(icpu_rdata), .o_icpu_busy(icpu_busy),
    .i_dcpu_ren(dcpu_ren), .i_dcpu_wen(dcpu_wen), .i_dcpu_addr(dcpu_addr),
    .i_dcpu_wdata(dcpu_wdata), .o_dcpu_rdata(dcpu_rdata), .o_dcpu_busy(dcpu_busy),
    .o_mem_ren(mem_ren), .o_mem_wen(mem_wen), .o_mem_addr(mem_addr),
    .o_mem_wdata(mem_wdata), .i_mem_rdata(mem_rdata), .i_mem_busy(mem_busy)
  );

  mem_model #(.WORDS(1024), .SEED(32'h08b22f34)) u_mem (
    .i_clk(clk), .i_ren(mem_ren), .i_wen(mem_wen), .i_addr(mem_addr),
    .i_wdata(mem_wdata), .o_rdata(mem_rdata), .o_busy(mem_busy)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // whole run bounded by vector count
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      abort_run($sformatf("run timed out after %0d cycles", cycle_limit));
    end
  end

  task automatic read_vectors();
    int         fd;
    int         code;
    int         fields;
    string      line;
    logic [7:0] op_c;
    logic [7:0] port_c;
    addr_t      a;
    word_t      w;
    word_t      e;
    fd = $fopen("bench/cache_input_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("could not open bench/cache_input_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        // skip blank and comment lines
        if (code != 0 && line.len() > 1 && line[0] != "#") begin
          fields = $sscanf(line, "%c %c %h %h %h", op_c, port_c, a, w, e);
          if (fields != 5) begin
            abort_run({"malformed vector line: ", line});
          end else begin
            vec_op.push_back(op_c);
            vec_port.push_back(port_c);
            vec_addr.push_back(a);
            vec_wdata.push_back(w);
            vec_exp.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // one or both read ports, each released once its busy drops
  task automatic issue_reads(input logic use_i, input addr_t ia, input word_t ie,
                             input logic use_d, input addr_t da, input word_t de);
    logic  i_open;
    logic  d_open;
    logic  i_fin;
    logic  d_fin;
    word_t i_got;
    word_t d_got;
    i_open = use_i;
    d_open = use_d;
    i_got  = '0;
    d_got  = '0;
    @(posedge clk);
    icpu_ren  <= use_i;
    icpu_addr <= ia;
    dcpu_ren  <= use_d;
    dcpu_addr <= da;
    while (i_open || d_open) begin
      // outputs settled mid cycle
      @(negedge clk);
      i_fin = i_open && !icpu_busy;
      d_fin = d_open && !dcpu_busy;
      if (i_fin) i_got = icpu_rdata;
      if (d_fin) d_got = dcpu_rdata;
      @(posedge clk);
      if (i_fin) begin
        icpu_ren <= 1'b0;
        i_open = 1'b0;
      end
      if (d_fin) begin
        dcpu_ren <= 1'b0;
        d_open = 1'b0;
      end
    end
    if (use_i) check_value("o_icpu_rdata", i_got, ie);
    if (use_d) check_value("o_dcpu_rdata", d_got, de);
  endtask

  task automatic cpu_write(input addr_t addr, input word_t wdata);
    logic fin;
    fin = 1'b0;
    @(posedge clk);
    dcpu_wen   <= 1'b1;
    dcpu_addr  <= addr;
    dcpu_wdata <= wdata;
    while (!fin) begin
      @(negedge clk);
      fin = !dcpu_busy;
    end
    @(posedge clk);
    dcpu_wen <= 1'b0;
  endtask

  // one-cycle command pulse, then wait for the merged done
  task automatic run_command(input logic is_flush);
    logic seen;
    seen = 1'b0;
    @(posedge clk);
    flush <= is_flush;
    clear <= !is_flush;
    @(posedge clk);
    flush <= 1'b0;
    clear <= 1'b0;
    while (!seen) begin
      @(negedge clk);
      seen = is_flush ? flush_done : clear_done;
    end
  endtask

  initial begin
    int k;
    rst        <= 1'b1;
    flush      <= 1'b0;
    clear      <= 1'b0;
    icpu_ren   <= 1'b0;
    icpu_addr  <= '0;
    dcpu_ren   <= 1'b0;
    dcpu_wen   <= 1'b0;
    dcpu_addr  <= '0;
    dcpu_wdata <= '0;
    read_vectors();
    cycle_limit = vec_op.size() * CYCLES_PER_VEC;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    k = 0;
    while (k < vec_op.size()) begin
      case (vec_op[k])
        "R": begin
          if (vec_port[k] == "I") issue_reads(1'b1, vec_addr[k], vec_exp[k], 1'b0, '0, '0);
          else issue_reads(1'b0, '0, '0, 1'b1, vec_addr[k], vec_exp[k]);
        end
        "W": begin
          if (vec_port[k] == "D") cpu_write(vec_addr[k], vec_wdata[k]);
          else abort_run("write vector on the instruction port, which cannot write");
        end
        "P": begin
          // instruction line first, data line right after
          if (k + 1 >= vec_op.size() || vec_op[k+1] != "P" || vec_port[k] != "I"
              || vec_port[k+1] != "D") begin
            abort_run("paired read vectors must be an I line followed by a D line");
          end else begin
            issue_reads(1'b1, vec_addr[k], vec_exp[k], 1'b1, vec_addr[k+1], vec_exp[k+1]);
            k++;
          end
        end
        "F": run_command(1'b1);
        "C": run_command(1'b0);
        "M": check_value("u_mem.mem_words", u_mem.mem_words[vec_addr[k][11:2]], vec_exp[k]);
        default: abort_run($sformatf("unknown operation code in vector %0d", k));
      endcase
      k++;
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- bench/mem_model.sv
/*
 * behavioral main memory on the generic bus
 * word array filled from the word address, random 0 to 3 cycle wait per transfer
 */

`timescale 1ns/1ps

module mem_model import cache_pkg::*; #(
  parameter int          WORDS = 1024,
  parameter logic [31:0] SEED  = 32'h08b22f34
) (
  input  logic  i_clk,
  input  logic  i_ren,
  input  logic  i_wen,
  input  addr_t i_addr,
  input  word_t i_wdata,
  output word_t o_rdata,
  output logic  o_busy
);

  localparam int AW = $clog2(WORDS);

  word_t         mem_words [WORDS];
  logic [1:0]    wait_left;
  logic [AW-1:0] widx;
  logic          req;

  assign req  = i_ren | i_wen;
  assign widx = i_addr[AW+1:2];

  // read data follows the address and is valid once busy drops
  assign o_rdata = mem_words[widx];
  assign o_busy  = req & (wait_left != 2'd0);

  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem_words[i] <= 32'hc0de0000 + i;
    end
    // first wait comes with the seed, this process draws every later one
    wait_left <= 2'($urandom(SEED) % 4);
    forever begin
      @(posedge i_clk);
      if (req && wait_left != 2'd0) begin
        wait_left <= wait_left - 2'd1;
      end else if (req) begin
        // transfer completes on this edge
        if (i_wen) begin
          mem_words[widx] <= i_wdata;
        end
        wait_left <= 2'($urandom % 4);
      end
    end
  end

endmodule

//--- src/cache_subsystem.sv
/*
 * top level, instruction and data L1 caches behind one memory arbiter
 * flush and clear done pulses merged across both caches
 */

`timescale 1ns/1ps

module cache_subsystem import cache_pkg::*; #(
  parameter int INDEX_W = L1_INDEX_W
) (
  input  logic  CLK,
  input  logic  i_rst,
  input  logic  i_flush,
  input  logic  i_clear,
  output logic  o_flush_done,
  output logic  o_clear_done,
  input  logic  i_icpu_ren,
  input  addr_t i_icpu_addr,
  output word_t o_icpu_rdata,
  output logic  o_icpu_busy,
  input  logic  i_dcpu_ren,
  input  logic  i_dcpu_wen,
  input  addr_t i_dcpu_addr,
  input  word_t i_dcpu_wdata,
  output word_t o_dcpu_rdata,
  output logic  o_dcpu_busy,
  output logic  o_mem_ren,
  output logic  o_mem_wen,
  output addr_t o_mem_addr,
  output word_t o_mem_wdata,
  input  word_t i_mem_rdata,
  input  logic  i_mem_busy
);

  // cache to arbiter buses
  logic  ic_ren, ic_wen, ic_busy;
  addr_t ic_addr;
  word_t ic_wdata, ic_rdata;
  logic  dc_ren, dc_wen, dc_busy;
  addr_t dc_addr;
  word_t dc_wdata, dc_rdata;

  // done bits, [1] clear and [0] flush
  logic [1:0] i_done;
  logic [1:0] d_done;
  logic [1:0] i_seen;
  logic [1:0] d_seen;
  logic [1:0] both_done;

  // instruction side is read only
  l1_cache #(.INDEX_W(INDEX_W)) u_icache (
    .CLK(CLK), .i_rst(i_rst), .i_flush(i_flush), .i_clear(i_clear),
    .o_flush_done(i_done[0]), .o_clear_done(i_done[1]),
    .i_cpu_ren(i_icpu_ren), .i_cpu_wen(1'b0), .i_cpu_addr(i_icpu_addr),
    .i_cpu_wdata('0), .o_cpu_rdata(o_icpu_rdata), .o_cpu_busy(o_icpu_busy),
    .o_mem_ren(ic_ren), .o_mem_wen(ic_wen), .o_mem_addr(ic_addr),
    .o_mem_wdata(ic_wdata), .i_mem_rdata(ic_rdata), .i_mem_busy(ic_busy)
  );

  l1_cache #(.INDEX_W(INDEX_W)) u_dcache (
    .CLK(CLK), .i_rst(i_rst), .i_flush(i_flush), .i_clear(i_clear),
    .o_flush_done(d_done[0]), .o_clear_done(d_done[1]),
    .i_cpu_ren(i_dcpu_ren), .i_cpu_wen(i_dcpu_wen), .i_cpu_addr(i_dcpu_addr),
    .i_cpu_wdata(i_dcpu_wdata), .o_cpu_rdata(o_dcpu_rdata), .o_cpu_busy(o_dcpu_busy),
    .o_mem_ren(dc_ren), .o_mem_wen(dc_wen), .o_mem_addr(dc_addr),
    .o_mem_wdata(dc_wdata), .i_mem_rdata(dc_rdata), .i_mem_busy(dc_busy)
  );

  memory_arbiter u_arb (
    .CLK(CLK), .i_rst(i_rst),
    .i_icache_ren(ic_ren), .i_icache_wen(ic_wen), .i_icache_addr(ic_addr),
    .i_icache_wdata(ic_wdata), .o_icache_rdata(ic_rdata), .o_icache_busy(ic_busy),
    .i_dcache_ren(dc_ren), .i_dcache_wen(dc_wen), .i_dcache_addr(dc_addr),
    .i_dcache_wdata(dc_wdata), .o_dcache_rdata(dc_rdata), .o_dcache_busy(dc_busy),
    .o_mem_ren(o_mem_ren), .o_mem_wen(o_mem_wen), .o_mem_addr(o_mem_addr),
    .o_mem_wdata(o_mem_wdata), .i_mem_rdata(i_mem_rdata), .i_mem_busy(i_mem_busy)
  );

  // pulse once both caches have reported, early one waits in seen
  assign both_done = (i_done | i_seen) & (d_done | d_seen);

  always_ff @(posedge CLK) begin
    if (i_rst) begin
      i_seen <= '0;
      d_seen <= '0;
    end else begin
      i_seen <= (i_seen | i_done) & ~both_done;
      d_seen <= (d_seen | d_done) & ~both_done;
    end
  end

  assign o_flush_done = both_done[0];
  assign o_clear_done = both_done[1];

endmodule

//--- src/memory_arbiter.sv
/*
 * two-requester arbiter onto one generic memory bus
 * dcache wins a tie, grant held until the transfer completes
 */

`timescale 1ns/1ps

module memory_arbiter import cache_pkg::*; (
  input  logic  CLK,
  input  logic  i_rst,
  input  logic  i_icache_ren,
  input  logic  i_icache_wen,
  input  addr_t i_icache_addr,
  input  word_t i_icache_wdata,
  output word_t o_icache_rdata,
  output logic  o_icache_busy,
  input  logic  i_dcache_ren,
  input  logic  i_dcache_wen,
  input  addr_t i_dcache_addr,
  input  word_t i_dcache_wdata,
  output word_t o_dcache_rdata,
  output logic  o_dcache_busy,
  output logic  o_mem_ren,
  output logic  o_mem_wen,
  output addr_t o_mem_addr,
  output word_t o_mem_wdata,
  input  word_t i_mem_rdata,
  input  logic  i_mem_busy
);

  // grant_d high means the dcache owns the bus
  logic grant_d;
  logic xfer_busy;
  logic sel_d;
  logic i_req;
  logic d_req;
  logic req;

  assign i_req = i_icache_ren | i_icache_wen;
  assign d_req = i_dcache_ren | i_dcache_wen;

  // idle bus picks a new owner, otherwise the stored grant
  always_comb begin
    if (xfer_busy) sel_d = grant_d;
    else if (d_req) sel_d = 1'b1;
    else if (i_req) sel_d = 1'b0;
    else sel_d = grant_d;
  end

  assign req = sel_d ? d_req : i_req;

  // request passes through for the selected side
  assign o_mem_ren   = sel_d ? i_dcache_ren   : i_icache_ren;
  assign o_mem_wen   = sel_d ? i_dcache_wen   : i_icache_wen;
  assign o_mem_addr  = sel_d ? i_dcache_addr  : i_icache_addr;
  assign o_mem_wdata = sel_d ? i_dcache_wdata : i_icache_wdata;

  // the side that lost sees busy until the bus frees up
  assign o_dcache_busy  = sel_d ? i_mem_busy : 1'b1;
  assign o_icache_busy  = sel_d ? 1'b1 : i_mem_busy;
  assign o_dcache_rdata = sel_d ? i_mem_rdata : '0;
  assign o_icache_rdata = sel_d ? '0 : i_mem_rdata;

  always_ff @(posedge CLK) begin
    if (i_rst) begin
      grant_d   <= 1'b0;
      xfer_busy <= 1'b0;
    end else if (req && i_mem_busy) begin
      grant_d   <= sel_d;
      xfer_busy <= 1'b1;
    end else if (req) begin
      // transfer completes this cycle
      xfer_busy <= 1'b0;
    end
  end

endmodule

//--- src/l1_cache.sv
/*
 * direct-mapped write-back, write-allocate L1 cache, one word per line
 * FSM for victim write-back, read fill, flush walk and clear walk
 * generic bus on both the CPU side and the memory side
 */

`timescale 1ns/1ps

module l1_cache import cache_pkg::*; #(
  parameter int INDEX_W = L1_INDEX_W
) (
  input  logic  CLK,
  input  logic  i_rst,
  input  logic  i_flush,
  input  logic  i_clear,
  output logic  o_flush_done,
  output logic  o_clear_done,
  input  logic  i_cpu_ren,
  input  logic  i_cpu_wen,
  input  addr_t i_cpu_addr,
  input  word_t i_cpu_wdata,
  output word_t o_cpu_rdata,
  output logic  o_cpu_busy,
  output logic  o_mem_ren,
  output logic  o_mem_wen,
  output addr_t o_mem_addr,
  output word_t o_mem_wdata,
  input  word_t i_mem_rdata,
  input  logic  i_mem_busy
);

  localparam int LINES = 2 ** INDEX_W;
  localparam int TAG_W = ADDR_W - 2 - INDEX_W;

  // FSM encoding
  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_WB    = 3'd1;
  localparam logic [2:0] ST_FILL  = 3'd2;
  localparam logic [2:0] ST_FLUSH = 3'd3;
  localparam logic [2:0] ST_CLEAR = 3'd4;

  // line storage
  logic [TAG_W-1:0] tag_mem [LINES];
  word_t            data_mem [LINES];
  logic [LINES-1:0] valid;
  logic [LINES-1:0] dirty;

  logic [2:0]         state;
  logic [2:0]         next_state;
  logic [INDEX_W-1:0] cnt;
  logic               flush_done_q;
  logic               clear_done_q;

  cache_addr_u        cpu_a;
  logic [ADDR_W-3:0]  cpu_line;
  logic [INDEX_W-1:0] cpu_idx;
  logic [TAG_W-1:0]   cpu_tag;
  logic               cpu_req;
  logic               hit;
  logic               victim_dirty;
  logic               wr_ok;
  logic               miss;
  logic [INDEX_W-1:0] wb_idx;
  logic               wb_line_dirty;
  logic               line_done;
  logic               last_line;

  // field view gives the line address, split again by INDEX_W
  assign cpu_a.raw = i_cpu_addr;
  assign cpu_line  = {cpu_a.fields.tag, cpu_a.fields.index};
  assign cpu_idx   = cpu_line[INDEX_W-1:0];
  assign cpu_tag   = cpu_line[ADDR_W-3:INDEX_W];

  assign cpu_req      = i_cpu_ren | i_cpu_wen;
  assign hit          = valid[cpu_idx] & (tag_mem[cpu_idx] == cpu_tag);
  assign victim_dirty = valid[cpu_idx] & dirty[cpu_idx] & ~hit;
  // write hit, or write miss over a clean victim, completes at once
  assign wr_ok        = i_cpu_wen & ~victim_dirty;
  assign miss         = cpu_req & ~hit & ~wr_ok;

  // write-back line, flush walks cnt, a miss evicts the CPU index
  assign wb_idx        = (state == ST_FLUSH) ? cnt : cpu_idx;
  assign wb_line_dirty = valid[wb_idx] & dirty[wb_idx];
  assign line_done     = ~wb_line_dirty | ~i_mem_busy;
  assign last_line     = &cnt;

  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE: begin
        if (miss) begin
          next_state = victim_dirty ? ST_WB : ST_FILL;
        end else if (i_flush) begin
          next_state = ST_FLUSH;
        end else if (i_clear) begin
          next_state = ST_CLEAR;
        end
      end
      // write miss returns to idle, victim now clean so the word installs
      ST_WB:    if (!i_mem_busy) next_state = i_cpu_ren ? ST_FILL : ST_IDLE;
      ST_FILL:  if (!i_mem_busy) next_state = ST_IDLE;
      ST_FLUSH: if (line_done && last_line) next_state = ST_IDLE;
      ST_CLEAR: if (last_line) next_state = ST_IDLE;
      default:  next_state = ST_IDLE;
    endcase
  end

  // control state and line status bits
  always_ff @(posedge CLK) begin
    if (i_rst) begin
      state        <= ST_IDLE;
      cnt          <= '0;
      valid        <= '0;
      dirty        <= '0;
      flush_done_q <= 1'b0;
      clear_done_q <= 1'b0;
    end else begin
      state        <= next_state;
      flush_done_q <= (state == ST_FLUSH) && line_done && last_line;
      clear_done_q <= (state == ST_CLEAR) && last_line;
      case (state)
        ST_IDLE: begin
          cnt <= '0;
          if (wr_ok) begin
            valid[cpu_idx] <= 1'b1;
            dirty[cpu_idx] <= 1'b1;
          end
        end
        ST_WB: if (!i_mem_busy) dirty[cpu_idx] <= 1'b0;
        ST_FILL: begin
          if (!i_mem_busy) begin
            valid[cpu_idx] <= 1'b1;
            dirty[cpu_idx] <= 1'b0;
          end
        end
        ST_FLUSH: begin
          if (line_done) begin
            dirty[cnt] <= 1'b0;
            cnt        <= cnt + 1'b1;
            // all written back, drop every line
            if (last_line) begin
              valid <= '0;
              dirty <= '0;
            end
          end
        end
        ST_CLEAR: begin
          valid[cnt] <= 1'b0;
          dirty[cnt] <= 1'b0;
          cnt        <= cnt + 1'b1;
        end
        default: cnt <= '0;
      endcase
    end
  end

  // tag and data arrays
  always_ff @(posedge CLK) begin
    if (state == ST_IDLE && wr_ok) begin
      tag_mem[cpu_idx]  <= cpu_tag;
      data_mem[cpu_idx] <= i_cpu_wdata;
    end else if (state == ST_FILL && !i_mem_busy) begin
      tag_mem[cpu_idx]  <= cpu_tag;
      data_mem[cpu_idx] <= i_mem_rdata;
    end
  end

  // memory side
  assign o_mem_ren   = (state == ST_FILL);
  assign o_mem_wen   = (state == ST_WB) | ((state == ST_FLUSH) & wb_line_dirty);
  assign o_mem_addr  = (state == ST_FILL) ? {cpu_a.raw[ADDR_W-1:2], 2'b00}
                                          : {tag_mem[wb_idx], wb_idx, 2'b00};
  assign o_mem_wdata = data_mem[wb_idx];

  // fill data goes straight through on the completing cycle
  assign o_cpu_rdata = (state == ST_FILL) ? i_mem_rdata : data_mem[cpu_idx];

  always_comb begin
    case (state)
      ST_IDLE: o_cpu_busy = miss;
      ST_FILL: o_cpu_busy = i_mem_busy;
      default: o_cpu_busy = 1'b1;
    endcase
  end

  assign o_flush_done = flush_done_q;
  assign o_clear_done = clear_done_q;

endmodule

//--- src/cache_pkg.sv
/*
 * shared bus types for the L1 caches and the memory arbiter
 * word and byte address types, address width, default index width
 * packed address union with raw and tag/index/offset views
 */

package cache_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // default number of index bits, top level passes it down as INDEX_W
  localparam int L1_INDEX_W = 4;

  // tag bits left over above the index and the byte offset
  localparam int L1_TAG_W = ADDR_W - L1_INDEX_W - 2;

  // one data word on any bus
  typedef logic [WORD_W-1:0] word_t;

  // byte address on any bus
  typedef logic [ADDR_W-1:0] addr_t;

  // cache view of an address
  // tag above index above the byte offset
  typedef struct packed {
    logic [L1_TAG_W-1:0]   tag;
    logic [L1_INDEX_W-1:0] index;
    logic [1:0]            offset;
  } cache_addr_fields_t;

  // same 32-bit address word, two decodes
  // raw goes out to memory, fields drive the lookup
  typedef union packed {
    addr_t              raw;
    cache_addr_fields_t fields;
  } cache_addr_u;

endpackage
